/* design/csr_pkg.sv */
package csr_pkg;

   typedef logic [63:0] word_t;
   typedef logic [11:0] csr_addr_t;
   typedef logic [3:0]  ecode_t;
   // Bit 0 software, bit 1 timer, bit 2 external
   typedef logic [2:0]  irq_vec_t;

   typedef enum logic [1:0]
   {
      priv_u = 2'd0,
      priv_m = 2'd3
   } priv_e;

   typedef enum logic [3:0]
   {
      op_csrrw,
      op_csrrs,
      op_csrrc,
      op_csrrwi,
      op_csrrsi,
      op_csrrci,
      op_ecall,
      op_ebreak,
      op_mret,
      op_wfi,
      op_take_irq,
      op_illegal
   } csr_op_e;

   localparam csr_addr_t addr_mstatus       = 12'h300;
   localparam csr_addr_t addr_misa          = 12'h301;
   localparam csr_addr_t addr_mie           = 12'h304;
   localparam csr_addr_t addr_mtvec         = 12'h305;
   localparam csr_addr_t addr_mcounteren    = 12'h306;
   localparam csr_addr_t addr_mcountinhibit = 12'h320;
   localparam csr_addr_t addr_mscratch      = 12'h340;
   localparam csr_addr_t addr_mepc          = 12'h341;
   localparam csr_addr_t addr_mcause        = 12'h342;
   localparam csr_addr_t addr_mtval         = 12'h343;
   localparam csr_addr_t addr_mip           = 12'h344;
   localparam csr_addr_t addr_mcycle        = 12'hb00;
   localparam csr_addr_t addr_minstret      = 12'hb02;
   localparam csr_addr_t addr_cycle         = 12'hc00;
   localparam csr_addr_t addr_instret       = 12'hc02;
   localparam csr_addr_t addr_mvendorid     = 12'hf11;
   localparam csr_addr_t addr_marchid       = 12'hf12;
   localparam csr_addr_t addr_mimpid        = 12'hf13;
   localparam csr_addr_t addr_mhartid       = 12'hf14;

   localparam ecode_t ecode_illegal    = 4'd2;
   localparam ecode_t ecode_breakpoint = 4'd3;
   localparam ecode_t ecode_ecall_u    = 4'd8;
   localparam ecode_t ecode_ecall_m    = 4'd11;
   localparam ecode_t ecode_irq_soft   = 4'd3;
   localparam ecode_t ecode_irq_timer  = 4'd7;
   localparam ecode_t ecode_irq_ext    = 4'd11;

   // mstatus field positions
   localparam int mstatus_mie_bit  = 3;
   localparam int mstatus_mpie_bit = 7;
   localparam int mstatus_mpp_lsb  = 11;
   localparam int mstatus_tw_bit   = 21;

   // RV64, extensions A I S U
   localparam word_t misa_value    = {2'b10, 36'b0, 26'h140101};
   localparam word_t marchid_value = 64'd13;
   localparam word_t mimpid_value  = 64'd1;

endpackage

/* design/csr_decode.sv */
`timescale 1ns/1ps

module csr_decode
  (input  logic                cmd_v_i
   , input  csr_pkg::csr_op_e  cmd_op_i
   , input  csr_pkg::csr_addr_t cmd_addr_i
   , input  csr_pkg::word_t    cmd_data_i
   , input  csr_pkg::word_t    rdata_i
   , input  csr_pkg::priv_e    priv_i
   , input  csr_pkg::word_t    mcounteren_i
   , input  logic              tw_i
   , output csr_pkg::word_t    wdata_o
   , output logic              wr_en_o
   , output logic              illegal_o
   , output logic              trap_v_o
   , output csr_pkg::ecode_t   cause_o
   , output logic              eret_v_o
   );

   import csr_pkg::*;

   word_t imm;
   logic  is_u;
   logic  known;
   logic  read_only;
   logic  csr_bad;

   assign imm  = word_t'(cmd_data_i[4:0]);
   assign is_u = (priv_i == priv_u);

   assign known = cmd_addr_i inside {addr_mstatus, addr_misa, addr_mie, addr_mtvec,
                                     addr_mcounteren, addr_mcountinhibit, addr_mscratch,
                                     addr_mepc, addr_mcause, addr_mtval, addr_mip,
                                     addr_mcycle, addr_minstret, addr_cycle, addr_instret,
                                     addr_mvendorid, addr_marchid, addr_mimpid, addr_mhartid};

   // Top address bits 11 mark the read-only space
   assign read_only = (cmd_addr_i == addr_misa) || (cmd_addr_i[11:10] == 2'b11);

   assign csr_bad = !known || (priv_i < cmd_addr_i[9:8])
                    || (is_u && (cmd_addr_i == addr_cycle) && !mcounteren_i[0])
                    || (is_u && (cmd_addr_i == addr_instret) && !mcounteren_i[2]);

   always_comb
   begin
      case (cmd_op_i)
         op_csrrw:  wdata_o = cmd_data_i;
         op_csrrs:  wdata_o = cmd_data_i | rdata_i;
         op_csrrc:  wdata_o = ~cmd_data_i & rdata_i;
         op_csrrwi: wdata_o = imm;
         op_csrrsi: wdata_o = imm | rdata_i;
         op_csrrci: wdata_o = ~imm & rdata_i;
         default:   wdata_o = '0;
      endcase
   end

   always_comb
   begin
      illegal_o = 1'b0;
      trap_v_o  = 1'b0;
      cause_o   = '0;
      eret_v_o  = 1'b0;
      wr_en_o   = 1'b0;
      if (cmd_v_i)
      begin
         case (cmd_op_i)
            op_csrrw, op_csrrs, op_csrrc, op_csrrwi, op_csrrsi, op_csrrci:
            begin
               illegal_o = csr_bad;
               wr_en_o   = !csr_bad && !read_only;
            end
            op_ecall:
            begin
               trap_v_o = 1'b1;
               cause_o  = is_u ? ecode_ecall_u : ecode_ecall_m;
            end
            op_ebreak:
            begin
               trap_v_o = 1'b1;
               cause_o  = ecode_breakpoint;
            end
            op_mret:
            begin
               illegal_o = is_u;
               eret_v_o  = !is_u;
            end
            // Otherwise a no-op here
            op_wfi:      illegal_o = is_u && tw_i;
            op_take_irq: illegal_o = 1'b0;
            default:     illegal_o = 1'b1;
         endcase
         if (illegal_o)
         begin
            trap_v_o = 1'b1;
            cause_o  = ecode_illegal;
         end
      end
      assert (!(trap_v_o && eret_v_o))
         else $error("csr_decode: trap and mret in the same command");
   end

endmodule

/* design/csr_irq_arbiter.sv */
`timescale 1ns/1ps

module csr_irq_arbiter
  (input  csr_pkg::irq_vec_t mip_i
   , input  csr_pkg::irq_vec_t mie_i
   , input  logic              global_en_i
   , output logic              irq_v_o
   , output csr_pkg::ecode_t   irq_code_o
   );

   import csr_pkg::*;

   irq_vec_t masked;

   always_comb
   begin
      masked  = mip_i & mie_i & {3{global_en_i}};
      irq_v_o = 1'b1;
      // Software first, external last
      if (masked[0])
         irq_code_o = ecode_irq_soft;
      else if (masked[1])
         irq_code_o = ecode_irq_timer;
      else if (masked[2])
         irq_code_o = ecode_irq_ext;
      else
      begin
         irq_v_o    = 1'b0;
         irq_code_o = '0;
      end
      assert (!irq_v_o || (masked != '0))
         else $error("csr_irq_arbiter: interrupt without a pending enabled source");
   end

endmodule

/* design/csr_counters.sv */
`timescale 1ns/1ps

module csr_counters
  (input  logic             clk_i
   , input  logic           rst_i
   , input  logic           instret_i
   , input  csr_pkg::word_t inhibit_i
   , input  logic           cycle_we_i
   , input  logic           instret_we_i
   , input  csr_pkg::word_t wdata_i
   , output csr_pkg::word_t mcycle_o
   , output csr_pkg::word_t minstret_o
   );

   import csr_pkg::*;

   // Software write wins over the count
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         mcycle_o   <= '0;
         minstret_o <= '0;
      end
      else
      begin
         if (cycle_we_i)
            mcycle_o <= wdata_i;
         else if (!inhibit_i[0])
            mcycle_o <= mcycle_o + word_t'(1);

         if (instret_we_i)
            minstret_o <= wdata_i;
         else if (!inhibit_i[2])
            minstret_o <= minstret_o + word_t'(instret_i);
      end
   end

   // Inhibited cycle counter holds its value
   cycle_hold_a : assert property (@(posedge clk_i) disable iff (rst_i)
      (inhibit_i[0] && !cycle_we_i) |=> $stable(mcycle_o));

endmodule

/* design/csr_regfile.sv */
`timescale 1ns/1ps

module csr_regfile
  #(parameter int pc_width_p = 39)
  (input  logic                     clk_i
   , input  logic                   rst_i
   , input  logic                   cmd_v_i
   , input  csr_pkg::csr_op_e       cmd_op_i
   , input  csr_pkg::csr_addr_t     cmd_addr_i
   , input  logic [pc_width_p-1:0]  cmd_pc_i
   , input  csr_pkg::word_t         cmd_instr_i
   , input  csr_pkg::word_t         hartid_i
   , input  csr_pkg::word_t         wdata_i
   , input  logic                   wr_en_i
   , input  logic                   trap_v_i
   , input  csr_pkg::ecode_t        cause_i
   , input  logic                   eret_v_i
   , input  logic                   irq_v_i
   , input  csr_pkg::ecode_t        irq_code_i
   , input  csr_pkg::irq_vec_t      irq_i
   , input  csr_pkg::word_t         mcycle_i
   , input  csr_pkg::word_t         minstret_i
   , output csr_pkg::word_t         rdata_o
   , output csr_pkg::priv_e         priv_o
   , output csr_pkg::word_t         mstatus_o
   , output csr_pkg::word_t         mcounteren_o
   , output csr_pkg::irq_vec_t      mie_o
   , output csr_pkg::irq_vec_t      mip_o
   , output csr_pkg::word_t         mcountinhibit_o
   , output logic                   cycle_we_o
   , output logic                   instret_we_o
   , output logic [pc_width_p-1:0]  trap_pc_o
   );

   import csr_pkg::*;

   logic  status_mie_r;
   logic  status_mpie_r;
   priv_e status_mpp_r;
   logic  status_tw_r;
   word_t mtvec_r;
   word_t mscratch_r;
   word_t mepc_r;
   word_t mcause_r;
   word_t mtval_r;
   logic  irq_trap;
   logic  take_trap;

   // Interrupt bits sit at 3, 7 and 11
   function automatic word_t irq_word(irq_vec_t v);
      word_t w;
      w     = '0;
      w[3]  = v[0];
      w[7]  = v[1];
      w[11] = v[2];
      return w;
   endfunction

   assign irq_trap  = cmd_v_i && (cmd_op_i == op_take_irq) && irq_v_i;
   assign take_trap = trap_v_i || irq_trap;

   assign cycle_we_o   = wr_en_i && (cmd_addr_i == addr_mcycle);
   assign instret_we_o = wr_en_i && (cmd_addr_i == addr_minstret);

   assign trap_pc_o = eret_v_i ? mepc_r[pc_width_p-1:0] : {mtvec_r[pc_width_p-1:2], 2'b00};

   always_comb
   begin
      mstatus_o                            = '0;
      mstatus_o[mstatus_mie_bit]           = status_mie_r;
      mstatus_o[mstatus_mpie_bit]          = status_mpie_r;
      mstatus_o[mstatus_mpp_lsb +: 2]      = status_mpp_r;
      mstatus_o[mstatus_tw_bit]            = status_tw_r;
   end

   always_comb
   begin
      case (cmd_addr_i)
         addr_mstatus:               rdata_o = mstatus_o;
         addr_misa:                  rdata_o = misa_value;
         addr_mie:                   rdata_o = irq_word(mie_o);
         addr_mip:                   rdata_o = irq_word(mip_o);
         addr_mtvec:                 rdata_o = mtvec_r;
         addr_mcounteren:            rdata_o = mcounteren_o;
         addr_mcountinhibit:         rdata_o = mcountinhibit_o;
         addr_mscratch:              rdata_o = mscratch_r;
         addr_mepc:                  rdata_o = mepc_r;
         addr_mcause:                rdata_o = mcause_r;
         addr_mtval:                 rdata_o = mtval_r;
         addr_mcycle, addr_cycle:    rdata_o = mcycle_i;
         addr_minstret, addr_instret: rdata_o = minstret_i;
         addr_marchid:               rdata_o = marchid_value;
         addr_mimpid:                rdata_o = mimpid_value;
         addr_mhartid:               rdata_o = hartid_i;
         default:                    rdata_o = '0;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         priv_o          <= priv_m;
         status_mie_r    <= 1'b0;
         status_mpie_r   <= 1'b0;
         status_mpp_r    <= priv_u;
         status_tw_r     <= 1'b0;
         mie_o           <= '0;
         mip_o           <= '0;
         mtvec_r         <= '0;
         mcounteren_o    <= '0;
         mcountinhibit_o <= '0;
         mscratch_r      <= '0;
         mepc_r          <= '0;
         mcause_r        <= '0;
         mtval_r         <= '0;
      end
      else
      begin
         mip_o <= irq_i;
         if (take_trap)
         begin
            priv_o        <= priv_m;
            status_mpp_r  <= priv_o;
            status_mpie_r <= status_mie_r;
            status_mie_r  <= 1'b0;
            mepc_r        <= word_t'($signed(cmd_pc_i));
            mcause_r      <= irq_trap ? {1'b1, 59'b0, irq_code_i} : word_t'(cause_i);
            mtval_r       <= (trap_v_i && (cause_i == ecode_illegal)) ? cmd_instr_i : '0;
         end
         else if (eret_v_i)
         begin
            priv_o        <= status_mpp_r;
            status_mie_r  <= status_mpie_r;
            status_mpie_r <= 1'b1;
            status_mpp_r  <= priv_u;
         end
         else if (wr_en_i)
         begin
            case (cmd_addr_i)
               addr_mstatus:
               begin
                  status_mie_r  <= wdata_i[mstatus_mie_bit];
                  status_mpie_r <= wdata_i[mstatus_mpie_bit];
                  // Only M and U exist
                  status_mpp_r  <= (wdata_i[mstatus_mpp_lsb +: 2] == 2'b11) ? priv_m : priv_u;
                  status_tw_r   <= wdata_i[mstatus_tw_bit];
               end
               addr_mie:           mie_o <= {wdata_i[11], wdata_i[7], wdata_i[3]};
               addr_mtvec:         mtvec_r <= wdata_i;
               addr_mcounteren:    mcounteren_o <= wdata_i;
               addr_mcountinhibit: mcountinhibit_o <= wdata_i;
               addr_mscratch:      mscratch_r <= wdata_i;
               addr_mepc:          mepc_r <= wdata_i;
               addr_mcause:        mcause_r <= wdata_i;
               addr_mtval:         mtval_r <= wdata_i;
               default:
               begin
               end
            endcase
         end
      end
   end

   // Any trap lands in machine mode with interrupts off
   trap_to_m_a : assert property (@(posedge clk_i) disable iff (rst_i)
      take_trap |=> (priv_o == priv_m) && !status_mie_r);

endmodule

/* design/csr_unit.sv */
`timescale 1ns/1ps

module csr_unit
  #(parameter int pc_width_p = 39)
  (input  logic                     clk_i
   , input  logic                   rst_i
   , input  logic                   cmd_v_i
   , input  csr_pkg::csr_op_e       cmd_op_i
   , input  csr_pkg::csr_addr_t     cmd_addr_i
   , input  csr_pkg::word_t         cmd_data_i
   , input  logic [pc_width_p-1:0]  cmd_pc_i
   , input  csr_pkg::word_t         cmd_instr_i
   , input  csr_pkg::word_t         hartid_i
   , input  logic                   instret_i
   , input  logic                   timer_irq_i
   , input  logic                   software_irq_i
   , input  logic                   external_irq_i
   , output csr_pkg::word_t         csr_data_o
   , output logic                   illegal_instr_o
   , output logic                   trap_v_o
   , output logic                   eret_v_o
   , output logic [pc_width_p-1:0]  trap_pc_o
   , output csr_pkg::priv_e         priv_mode_o
   , output logic                   accept_irq_o
   );

   import csr_pkg::*;

   word_t    wdata;
   logic     wr_en;
   ecode_t   cause;
   ecode_t   irq_code;
   word_t    mstatus;
   word_t    mcounteren;
   word_t    mcountinhibit;
   irq_vec_t mie;
   irq_vec_t mip;
   logic     global_en;
   logic     cycle_we;
   logic     instret_we;
   word_t    mcycle;
   word_t    minstret;

   // User mode always takes machine interrupts
   assign global_en = mstatus[mstatus_mie_bit] || (priv_mode_o == priv_u);

   csr_decode u_decode
     (.cmd_v_i      (cmd_v_i)
      , .cmd_op_i     (cmd_op_i)
      , .cmd_addr_i   (cmd_addr_i)
      , .cmd_data_i   (cmd_data_i)
      , .rdata_i      (csr_data_o)
      , .priv_i       (priv_mode_o)
      , .mcounteren_i (mcounteren)
      , .tw_i         (mstatus[mstatus_tw_bit])
      , .wdata_o      (wdata)
      , .wr_en_o      (wr_en)
      , .illegal_o    (illegal_instr_o)
      , .trap_v_o     (trap_v_o)
      , .cause_o      (cause)
      , .eret_v_o     (eret_v_o)
      );

   csr_irq_arbiter u_irq_arbiter
     (.mip_i         (mip)
      , .mie_i       (mie)
      , .global_en_i (global_en)
      , .irq_v_o     (accept_irq_o)
      , .irq_code_o  (irq_code)
      );

   csr_counters u_counters
     (.clk_i          (clk_i)
      , .rst_i        (rst_i)
      , .instret_i    (instret_i)
      , .inhibit_i    (mcountinhibit)
      , .cycle_we_i   (cycle_we)
      , .instret_we_i (instret_we)
      , .wdata_i      (wdata)
      , .mcycle_o     (mcycle)
      , .minstret_o   (minstret)
      );

   csr_regfile #(.pc_width_p(pc_width_p)) u_regfile
     (.clk_i             (clk_i)
      , .rst_i           (rst_i)
      , .cmd_v_i         (cmd_v_i)
      , .cmd_op_i        (cmd_op_i)
      , .cmd_addr_i      (cmd_addr_i)
      , .cmd_pc_i        (cmd_pc_i)
      , .cmd_instr_i     (cmd_instr_i)
      , .hartid_i        (hartid_i)
      , .wdata_i         (wdata)
      , .wr_en_i         (wr_en)
      , .trap_v_i        (trap_v_o)
      , .cause_i         (cause)
      , .eret_v_i        (eret_v_o)
      , .irq_v_i         (accept_irq_o)
      , .irq_code_i      (irq_code)
      , .irq_i           ({external_irq_i, timer_irq_i, software_irq_i})
      , .mcycle_i        (mcycle)
      , .minstret_i      (minstret)
      , .rdata_o         (csr_data_o)
      , .priv_o          (priv_mode_o)
      , .mstatus_o       (mstatus)
      , .mcounteren_o    (mcounteren)
      , .mie_o           (mie)
      , .mip_o           (mip)
      , .mcountinhibit_o (mcountinhibit)
      , .cycle_we_o      (cycle_we)
      , .instret_we_o    (instret_we)
      , .trap_pc_o       (trap_pc_o)
      );

endmodule

/* include/csr_tb_model.svh */
`ifndef CSR_TB_MODEL_SVH
`define CSR_TB_MODEL_SVH

// Shadow copies of the machine CSRs the bench follows
word_t sh_mscratch;
word_t sh_mtvec;
word_t sh_mepc;
word_t sh_mcause;
word_t sh_mtval;
priv_e sh_priv;
logic  sh_mie;
logic  sh_mpie;
priv_e sh_mpp;
logic  sh_tw;

task automatic reset_shadow();
   sh_mscratch = '0;
   sh_mtvec    = '0;
   sh_mepc     = '0;
   sh_mcause   = '0;
   sh_mtval    = '0;
   sh_priv     = priv_m;
   sh_mie      = 1'b0;
   sh_mpie     = 1'b0;
   sh_mpp      = priv_u;
   sh_tw       = 1'b0;
endtask

function automatic word_t shadow_mstatus();
   word_t w;
   w        = '0;
   w[3]     = sh_mie;
   w[7]     = sh_mpie;
   w[12:11] = sh_mpp;
   w[21]    = sh_tw;
   return w;
endfunction

function automatic bit is_shadowed(csr_addr_t a);
   return a inside {addr_mscratch, addr_mtvec, addr_mepc, addr_mcause, addr_mtval,
                    addr_mstatus};
endfunction

function automatic word_t shadow_read(csr_addr_t a);
   case (a)
      addr_mscratch: return sh_mscratch;
      addr_mtvec:    return sh_mtvec;
      addr_mepc:     return sh_mepc;
      addr_mcause:   return sh_mcause;
      addr_mtval:    return sh_mtval;
      addr_mstatus:  return shadow_mstatus();
      default:       return '0;
   endcase
endfunction

// Write, set or clear with a register or a 5-bit immediate source
function automatic word_t rmw_result(csr_op_e op, word_t old, word_t src);
   word_t s;
   s = (op inside {op_csrrwi, op_csrrsi, op_csrrci}) ? {59'b0, src[4:0]} : src;
   if (op == op_csrrw || op == op_csrrwi)
      return s;
   else if (op == op_csrrs || op == op_csrrsi)
      return old | s;
   else
      return old & ~s;
endfunction

function automatic void apply_write(csr_addr_t a, word_t v);
   case (a)
      addr_mscratch: sh_mscratch = v;
      addr_mtvec:    sh_mtvec = v;
      addr_mepc:     sh_mepc = v;
      addr_mcause:   sh_mcause = v;
      addr_mtval:    sh_mtval = v;
      addr_mstatus:
      begin
         sh_mie  = v[3];
         sh_mpie = v[7];
         sh_mpp  = (v[12:11] == 2'b11) ? priv_m : priv_u;
         sh_tw   = v[21];
      end
      default:
      begin
      end
   endcase
endfunction

// Trap entry uses the PC and instruction still on the command inputs
function automatic void enter_trap(word_t cause_word, bit illegal);
   sh_mepc   = {{(64 - pc_w){cmd_pc[pc_w-1]}}, cmd_pc};
   sh_mcause = cause_word;
   sh_mtval  = illegal ? cmd_instr : '0;
   sh_mpp    = sh_priv;
   sh_mpie   = sh_mie;
   sh_mie    = 1'b0;
   sh_priv   = priv_m;
endfunction

function automatic word_t trap_target();
   return {{(64 - pc_w){1'b0}}, sh_mtvec[pc_w-1:2], 2'b00};
endfunction

`endif

/* bench/csr_unit_tb.sv */
`timescale 1ns/1ps

module csr_unit_tb;

   import csr_pkg::*;

   localparam int pc_w           = 39;
   localparam int clk_period     = 4;
   // Budget of commands, each allowed two cycles
   localparam int cmd_budget     = 2500;
   localparam int cycles_per_cmd = 2;

   logic            clk;
   logic            rst;
   logic            cmd_v;
   csr_op_e         cmd_op;
   csr_addr_t       cmd_addr;
   word_t           cmd_data;
   logic [pc_w-1:0] cmd_pc;
   word_t           cmd_instr;
   word_t           hartid;
   logic            instret;
   logic            timer_irq;
   logic            software_irq;
   logic            external_irq;
   word_t           csr_data;
   logic            illegal_instr;
   logic            trap_v;
   logic            eret_v;
   logic [pc_w-1:0] trap_pc;
   priv_e           priv_mode;
   logic            accept_irq;

   csr_unit #(.pc_width_p(pc_w)) u_csr_unit
     (.clk_i            (clk)
      , .rst_i          (rst)
      , .cmd_v_i        (cmd_v)
      , .cmd_op_i       (cmd_op)
      , .cmd_addr_i     (cmd_addr)
      , .cmd_data_i     (cmd_data)
      , .cmd_pc_i       (cmd_pc)
      , .cmd_instr_i    (cmd_instr)
      , .hartid_i       (hartid)
      , .instret_i      (instret)
      , .timer_irq_i    (timer_irq)
      , .software_irq_i (software_irq)
      , .external_irq_i (external_irq)
      , .csr_data_o     (csr_data)
      , .illegal_instr_o (illegal_instr)
      , .trap_v_o       (trap_v)
      , .eret_v_o       (eret_v)
      , .trap_pc_o      (trap_pc)
      , .priv_mode_o    (priv_mode)
      , .accept_irq_o   (accept_irq)
      );

   always #(clk_period / 2) clk = ~clk;

   task automatic compare_word(input string name, input word_t exp, input word_t act);
      assert (act === exp)
      else
      begin
         $display("ERR %s expected %h actual %h", name, exp, act);
         $display("** FAIL **");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic confirm(input logic cond, input string what);
      assert (cond === 1'b1)
      else
      begin
         $display("Check failed: %s", what);
         $display("** FAIL **");
         $fatal(1, "check failed");
      end
   endtask

   `include "csr_tb_model.svh"

   task automatic idle_cycles(input int n);
      repeat (n)
      begin
         @(posedge clk);
         #1;
      end
   endtask

   // Outputs are sampled 3 ns after the edge, well before the next one
   task automatic issue(input csr_op_e op, input csr_addr_t addr, input word_t data);
      word_t r;
      r         = {$urandom, $urandom};
      cmd_v     = 1'b1;
      cmd_op    = op;
      cmd_addr  = addr;
      cmd_data  = data;
      cmd_pc    = r[pc_w-1:0];
      cmd_instr = {32'b0, $urandom};
      #2;
   endtask

   task automatic retire();
      @(posedge clk);
      #1;
      cmd_v = 1'b0;
   endtask

   task automatic access_csr(input string name, input csr_op_e op, input csr_addr_t addr,
                             input word_t data);
      word_t old;
      old = shadow_read(addr);
      issue(op, addr, data);
      confirm(!illegal_instr && !trap_v, {name, " raised a trap"});
      if (is_shadowed(addr))
         compare_word(name, old, csr_data);
      retire();
      if (is_shadowed(addr))
         apply_write(addr, rmw_result(op, old, data));
   endtask

   task automatic sample_csr(input csr_addr_t addr, output word_t val);
      issue(op_csrrsi, addr, '0);
      confirm(!illegal_instr && !trap_v, "CSR read raised a trap");
      val = csr_data;
      retire();
   endtask

   task automatic expect_trap(input string name, input csr_op_e op, input csr_addr_t addr,
                              input ecode_t cause);
      issue(op, addr, '0);
      confirm(trap_v, {name, " did not trap"});
      confirm(illegal_instr == (cause == ecode_illegal), {name, " has a wrong illegal flag"});
      compare_word({name, " trap_pc"}, trap_target(), word_t'(trap_pc));
      retire();
      enter_trap(word_t'(cause), cause == ecode_illegal);
      compare_word({name, " priv"}, word_t'(sh_priv), word_t'(priv_mode));
   endtask

   task automatic return_mret(input string name);
      issue(op_mret, addr_mstatus, '0);
      confirm(eret_v && !trap_v, {name, " was not taken as mret"});
      compare_word({name, " trap_pc"}, word_t'(sh_mepc[pc_w-1:0]), word_t'(trap_pc));
      retire();
      sh_priv = sh_mpp;
      sh_mie  = sh_mpie;
      sh_mpie = 1'b1;
      sh_mpp  = priv_u;
      compare_word({name, " priv"}, word_t'(sh_priv), word_t'(priv_mode));
   endtask

   task automatic verify_trap_csrs(input string name);
      access_csr({name, " mcause"}, op_csrrsi, addr_mcause, '0);
      access_csr({name, " mepc"}, op_csrrsi, addr_mepc, '0);
      access_csr({name, " mtval"}, op_csrrsi, addr_mtval, '0);
      access_csr({name, " mstatus"}, op_csrrsi, addr_mstatus, '0);
   endtask

   task automatic wait_accept();
      int waited;
      waited = 0;
      while (!accept_irq && waited < 2)
      begin
         @(posedge clk);
         #1;
         waited++;
      end
      confirm(accept_irq, "accept_irq_o did not rise within two cycles");
   endtask

   initial
   begin
      #(cmd_budget * cycles_per_cmd * clk_period);
      $display("Timeout: the run did not finish within its command budget");
      $display("** FAIL **");
      $fatal(1, "watchdog expired");
   end

   initial
   begin
      word_t seed_draw;
      word_t v1;
      word_t v2;
      int    pulses;
      seed_draw    = word_t'($urandom(32'h1113));
      clk          = 1'b0;
      rst          = 1'b1;
      cmd_v        = 1'b0;
      cmd_op       = op_csrrs;
      cmd_addr     = '0;
      cmd_data     = '0;
      cmd_pc       = '0;
      cmd_instr    = '0;
      hartid       = 64'h0000_0000_0000_0005 ^ seed_draw[7:0];
      instret      = 1'b0;
      timer_irq    = 1'b0;
      software_irq = 1'b0;
      external_irq = 1'b0;
      reset_shadow();
      repeat (5) @(posedge clk);
      #1;
      rst = 1'b0;
      confirm(!illegal_instr && !trap_v && !eret_v && !accept_irq, "control high after reset");
      compare_word("reset priv", word_t'(priv_m), word_t'(priv_mode));

      // Random data through mscratch, every operation twice
      for (int i = 0; i < 12; i++)
         access_csr("mscratch rmw", csr_op_e'(i % 6), addr_mscratch, {$urandom, $urandom});
      access_csr("mscratch final", op_csrrsi, addr_mscratch, '0);

      sample_csr(addr_mhartid, v1);
      compare_word("mhartid", hartid, v1);
      access_csr("misa write", op_csrrw, addr_misa, {$urandom, $urandom});
      sample_csr(addr_misa, v1);
      compare_word("misa", 64'h8000_0000_0014_0101, v1);
      sample_csr(addr_marchid, v1);
      compare_word("marchid", 64'd13, v1);
      sample_csr(addr_mimpid, v1);
      compare_word("mimpid", 64'd1, v1);
      access_csr("mtvec", op_csrrw, addr_mtvec, 64'h0000_0000_8000_0103);
      expect_trap("unknown csr", op_csrrw, 12'h7c0, ecode_illegal);
      verify_trap_csrs("unknown csr");

      expect_trap("ecall m", op_ecall, addr_mstatus, ecode_ecall_m);
      verify_trap_csrs("ecall m");
      access_csr("mpp to user", op_csrrc, addr_mstatus, 64'h1800);
      return_mret("mret to user");
      expect_trap("user mstatus", op_csrrs, addr_mstatus, ecode_illegal);
      verify_trap_csrs("user mstatus");
      return_mret("mret again");
      expect_trap("ecall u", op_ecall, addr_mstatus, ecode_ecall_u);
      verify_trap_csrs("ecall u");

      // Counter access from user mode
      return_mret("mret cycle");
      expect_trap("cycle locked", op_csrrs, addr_cycle, ecode_illegal);
      verify_trap_csrs("cycle locked");
      access_csr("mcounteren", op_csrrsi, addr_mcounteren, 64'd1);
      return_mret("mret cycle open");
      sample_csr(addr_cycle, v1);
      expect_trap("ecall back", op_ecall, addr_mstatus, ecode_ecall_u);

      access_csr("mie", op_csrrw, addr_mie, 64'h888);
      access_csr("mstatus mie", op_csrrsi, addr_mstatus, 64'd8);
      timer_irq    = 1'b1;
      external_irq = 1'b1;
      wait_accept();
      issue(op_take_irq, addr_mstatus, '0);
      compare_word("irq trap_pc", trap_target(), word_t'(trap_pc));
      retire();
      enter_trap(64'h8000_0000_0000_0007, 1'b0);
      compare_word("irq priv", word_t'(sh_priv), word_t'(priv_mode));
      confirm(!accept_irq, "accept_irq_o high with interrupts disabled");
      verify_trap_csrs("irq");
      timer_irq    = 1'b0;
      external_irq = 1'b0;

      sample_csr(addr_mcycle, v1);
      idle_cycles(3);
      sample_csr(addr_mcycle, v2);
      confirm(v2 > v1, "mcycle did not advance between two reads");
      access_csr("inhibit cycle", op_csrrsi, addr_mcountinhibit, 64'd1);
      sample_csr(addr_mcycle, v1);
      idle_cycles(3);
      sample_csr(addr_mcycle, v2);
      compare_word("mcycle inhibited", v1, v2);
      access_csr("release inhibit", op_csrrw, addr_mcountinhibit, '0);
      sample_csr(addr_minstret, v1);
      pulses = $urandom_range(3, 9);
      repeat (pulses)
      begin
         instret = 1'b1;
         idle_cycles(1);
         instret = 1'b0;
         idle_cycles(1);
      end
      sample_csr(addr_minstret, v2);
      compare_word("minstret", v1 + word_t'(pulses), v2);

      $display("** PASS **");
      $finish;
   end

endmodule

/* files.f */
+incdir+include
design/csr_pkg.sv
design/csr_decode.sv
design/csr_irq_arbiter.sv
design/csr_counters.sv
design/csr_regfile.sv
design/csr_unit.sv
bench/csr_unit_tb.sv

/* Makefile */
SRCS := $(shell grep -v '^+' files.f) include/csr_tb_model.svh

.PHONY: all run clean

all: obj_dir/Vcsr_unit_tb

obj_dir/Vcsr_unit_tb: files.f $(SRCS)
	verilator --binary --timing --assert -f files.f --top-module csr_unit_tb

run: obj_dir/Vcsr_unit_tb
	./obj_dir/Vcsr_unit_tb | tee /dev/stderr | grep -q -F '** PASS **'

clean:
	rm -rf obj_dir
